/* bench/sya_input.txt */
// Job count, then per job: chn shift zp ofm_base act_base wgt_base,
// chn lines of activation and weight vectors, then the four expected rows
3
// chn 1, shift 1, zp f0
01 01 f0 0100 0200 0300
0103ff02 0afe0405
fa00f4f5 00f10000 ff00f6f7 f500f2f2
// chn 8, shift 2, zp d0
08 02 d0 1000 2040 3080
0afd0201 10ff0001
0afd0202 10ff0101
0afd0203 10ff0201
0afd0204 10ff0301
0afd0205 10ff0401
0afd0206 10ff0501
0afd0207 10ff0601
0afd0208 10ff0701
6000fad9 1000ded4 00d60000 100016e4
// chn 4, shift 3, zp 05, output addresses wrap past ffff
04 03 05 fffe 4000 5000
00ff0004 20fb0201
00ff0104 20fb0202
00ff0204 20fb0203
00ff0304 20fb0204
4500090a 1d000607 00070000 05050505

/* bench/tb_sya_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sya_defs.svh"

module tb_sya_top
    import sya_pkg::*;
;

    localparam int CFG_TIMEOUT = 50;
    localparam int JOB_TIMEOUT = 500;

    logic       clk;
    logic       rst_n;
    logic       cfg_vld;
    logic       cfg_rdy;
    cfg_t       cfg_info;
    logic       rd_addr_vld;
    logic       rd_addr_rdy;
    glb_addr_t  act_rd_addr;
    glb_addr_t  wgt_rd_addr;
    logic       rd_dat_vld;
    vec_t       act_rd_dat;
    vec_t       wgt_rd_dat;
    logic       ofm_wr_vld;
    logic       ofm_wr_rdy;
    glb_addr_t  ofm_wr_addr;
    vec_t       ofm_wr_dat;

    // Stimulus words and the current job
    logic [31:0] stim [0:127];
    int          ptr;
    int          job_chn;
    glb_addr_t   job_ofm_base;
    glb_addr_t   job_act_base;
    glb_addr_t   job_wgt_base;
    vec_t        job_act [0:15];
    vec_t        job_wgt [0:15];
    vec_t        job_exp [0:`SYA_DIM-1];

    // Bookkeeping
    string       test_name;
    int          job_err;
    int          pass_cnt;
    int          fail_cnt;
    logic        timed_out;
    logic        job_reset;
    logic        job_busy;

    // Buffer model state
    int          cyc;
    int          req_cnt;
    int          wr_cnt;
    logic        rd_held;
    logic        wr_held;
    glb_addr_t   held_act;
    glb_addr_t   held_wgt;
    glb_addr_t   held_wr_addr;
    vec_t        held_wr_dat;
    int          rsp_off [$];
    int          rsp_due [$];

    sya_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_vld     (cfg_vld),
        .cfg_rdy     (cfg_rdy),
        .cfg_info    (cfg_info),
        .rd_addr_vld (rd_addr_vld),
        .rd_addr_rdy (rd_addr_rdy),
        .act_rd_addr (act_rd_addr),
        .wgt_rd_addr (wgt_rd_addr),
        .rd_dat_vld  (rd_dat_vld),
        .act_rd_dat  (act_rd_dat),
        .wgt_rd_dat  (wgt_rd_dat),
        .ofm_wr_vld  (ofm_wr_vld),
        .ofm_wr_rdy  (ofm_wr_rdy),
        .ofm_wr_addr (ofm_wr_addr),
        .ofm_wr_dat  (ofm_wr_dat)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================
    // Compare and report
    // ========================================
    task automatic check_row(string what, vec_t expected, vec_t actual);
        if (expected !== actual) begin
            $display("FAIL %s: %s expected %h actual %h", test_name, what, expected, actual);
            job_err++;
        end
    endtask

    task automatic check_addr(string what, glb_addr_t expected, glb_addr_t actual);
        if (expected !== actual) begin
            $display("FAIL %s: %s expected %h actual %h", test_name, what, expected, actual);
            job_err++;
        end
    endtask

    task automatic check_flag(string what, logic expected, logic actual);
        if (expected !== actual) begin
            $display("FAIL %s: %s expected %b actual %b", test_name, what, expected, actual);
            job_err++;
        end
    endtask

    task automatic report_error(string what);
        $display("ERROR %s: %s", test_name, what);
        job_err++;
    endtask

    task automatic finish_test();
        if (job_err == 0) begin
            pass_cnt++;
            $display("test %s passed", test_name);
        end else begin
            fail_cnt++;
            $display("test %s failed with %0d errors", test_name, job_err);
        end
    endtask

    // ========================================
    // Global buffer model
    // ========================================
    // Sampled on the rising edge, before the DUT registers update
    task automatic observe_bus();
        int off;
        cyc++;
        if (job_reset) begin
            req_cnt = 0;
            wr_cnt  = 0;
            rd_held = 1'b0;
            wr_held = 1'b0;
            rsp_off.delete();
            rsp_due.delete();
        end
        if (job_busy && wr_cnt < `SYA_DIM) begin
            check_flag("cfg_rdy during job", 1'b0, cfg_rdy);
        end

        if (rd_addr_vld) begin
            if (rd_held) begin
                check_addr("act read address held", held_act, act_rd_addr);
                check_addr("wgt read address held", held_wgt, wgt_rd_addr);
            end
            if (rd_addr_rdy) begin
                rd_held = 1'b0;
                if (req_cnt >= job_chn) begin
                    report_error("read request beyond the channel count");
                end else begin
                    check_addr("act read address", job_act_base + glb_addr_t'(req_cnt),
                               act_rd_addr);
                    check_addr("wgt read address", job_wgt_base + glb_addr_t'(req_cnt),
                               wgt_rd_addr);
                    off = int'(glb_addr_t'(act_rd_addr - job_act_base));
                    if (off >= job_chn) begin
                        report_error("read address outside the job vectors");
                        off = 0;
                    end
                    rsp_off.push_back(off);
                    rsp_due.push_back(cyc + int'($urandom_range(2, 0)));
                    req_cnt++;
                end
            end else begin
                rd_held  = 1'b1;
                held_act = act_rd_addr;
                held_wgt = wgt_rd_addr;
            end
        end else if (rd_held) begin
            report_error("read request withdrawn before acceptance");
            rd_held = 1'b0;
        end

        if (ofm_wr_vld) begin
            if (wr_held) begin
                check_addr("write address held", held_wr_addr, ofm_wr_addr);
                check_row("write data held", held_wr_dat, ofm_wr_dat);
            end
            if (ofm_wr_rdy) begin
                wr_held = 1'b0;
                if (wr_cnt >= `SYA_DIM) begin
                    report_error("more than four rows written");
                end else begin
                    check_addr("write address", job_ofm_base + glb_addr_t'(wr_cnt), ofm_wr_addr);
                    check_row($sformatf("row %0d", wr_cnt), job_exp[wr_cnt], ofm_wr_dat);
                    wr_cnt++;
                end
            end else begin
                wr_held      = 1'b1;
                held_wr_addr = ofm_wr_addr;
                held_wr_dat  = ofm_wr_dat;
            end
        end else if (wr_held) begin
            report_error("write valid dropped before acceptance");
            wr_held = 1'b0;
        end
    endtask

    // Random ready stalls, in-order read data after 1 to 3 cycles
    task automatic drive_bus();
        rd_addr_rdy = ($urandom_range(3, 0) != 0);
        ofm_wr_rdy  = ($urandom_range(2, 0) != 0);
        if (rsp_off.size() > 0 && rsp_due[0] <= cyc) begin
            rd_dat_vld = 1'b1;
            act_rd_dat = job_act[rsp_off[0]];
            wgt_rd_dat = job_wgt[rsp_off[0]];
            void'(rsp_off.pop_front());
            void'(rsp_due.pop_front());
        end else begin
            rd_dat_vld = 1'b0;
            act_rd_dat = $urandom;
            wgt_rd_dat = $urandom;
        end
    endtask

    initial begin : glb_model
        rd_addr_rdy = 1'b0;
        ofm_wr_rdy  = 1'b0;
        rd_dat_vld  = 1'b0;
        act_rd_dat  = '0;
        wgt_rd_dat  = '0;
        forever begin
            @(posedge clk);
            observe_bus();
            @(negedge clk);
            drive_bus();
        end
    end

    // ========================================
    // Tests
    // ========================================
    task automatic check_reset();
        test_name = "reset_state";
        job_err   = 0;
        rst_n     = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        check_flag("cfg_rdy after reset", 1'b1, cfg_rdy);
        check_flag("rd_addr_vld after reset", 1'b0, rd_addr_vld);
        check_flag("ofm_wr_vld after reset", 1'b0, ofm_wr_vld);
        finish_test();
    endtask

    task automatic run_job(int idx);
        cfg_t cfg;
        int   waited;
        int   k;
        job_chn      = int'(stim[ptr]);
        job_ofm_base = glb_addr_t'(stim[ptr+3]);
        job_act_base = glb_addr_t'(stim[ptr+4]);
        job_wgt_base = glb_addr_t'(stim[ptr+5]);
        cfg = '0;
        cfg[`SYA_CFG_OFM_LSB +: `SYA_ADDR_W]     = job_ofm_base;
        cfg[`SYA_CFG_ACT_LSB +: `SYA_ADDR_W]     = job_act_base;
        cfg[`SYA_CFG_WGT_LSB +: `SYA_ADDR_W]     = job_wgt_base;
        cfg[`SYA_CFG_CHN_LSB +: `SYA_CHN_W]      = chn_t'(job_chn);
        cfg[`SYA_CFG_SHIFT_LSB +: `SYA_SHIFT_W]  = shift_t'(stim[ptr+1]);
        cfg[`SYA_CFG_ZP_LSB +: `SYA_DATA_W]      = data_t'(stim[ptr+2]);
        cfg[7:0] = 8'($urandom);
        ptr = ptr + 6;
        for (k = 0; k < job_chn; k++) begin
            job_act[k] = vec_t'(stim[ptr]);
            job_wgt[k] = vec_t'(stim[ptr+1]);
            ptr = ptr + 2;
        end
        for (k = 0; k < `SYA_DIM; k++) begin
            job_exp[k] = vec_t'(stim[ptr]);
            ptr++;
        end
        test_name = $sformatf("job%0d_chn%0d", idx, job_chn);
        job_err   = 0;

        @(negedge clk);
        job_reset = 1'b1;
        cfg_info  = cfg;
        cfg_vld   = 1'b1;
        waited    = 0;
        @(posedge clk);
        while (!cfg_rdy && waited < CFG_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!cfg_rdy) begin
            report_error("configuration was not accepted in time");
            timed_out = 1'b1;
        end
        @(negedge clk);
        cfg_vld   = 1'b0;
        job_reset = 1'b0;
        // Scrambled so that only the latched fields matter
        cfg_info  = cfg_t'({$urandom, $urandom, $urandom});

        if (!timed_out) begin
            job_busy = 1'b1;
            waited   = 0;
            while (wr_cnt < `SYA_DIM && waited < JOB_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            job_busy = 1'b0;
            if (wr_cnt < `SYA_DIM) begin
                report_error("job did not write all four rows in time");
                timed_out = 1'b1;
            end else begin
                check_flag("cfg_rdy after last row", 1'b1, cfg_rdy);
                check_flag("read request count matches chn", 1'b1, req_cnt == job_chn);
            end
        end
        finish_test();
    endtask

    initial begin : main_seq
        int n_jobs;
        int j;
        void'($urandom(32'hb198_0e66));
        rst_n        = 1'b0;
        cfg_vld      = 1'b0;
        cfg_info     = '0;
        job_reset    = 1'b0;
        job_busy     = 1'b0;
        timed_out    = 1'b0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        job_err      = 0;
        job_chn      = 0;
        job_ofm_base = '0;
        job_act_base = '0;
        job_wgt_base = '0;
        test_name    = "setup";
        $readmemh("bench/sya_input.txt", stim);
        n_jobs = 0;
        if ($isunknown(stim[0]) || stim[0] == 0) begin
            $display("ERROR no jobs could be read from bench/sya_input.txt");
            fail_cnt++;
        end else begin
            n_jobs = int'(stim[0]);
        end
        ptr = 1;

        check_reset();
        for (j = 0; j < n_jobs; j++) begin
            if (!timed_out) begin
                run_job(j + 1);
            end
        end

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* common/sya_defs.svh */
`ifndef SYA_DEFS_SVH
`define SYA_DEFS_SVH

// Array geometry and datapath widths
`define SYA_DIM          4
`define SYA_DATA_W       8
`define SYA_ADDR_W       16
`define SYA_CHN_W        8
`define SYA_PSUM_W       24
`define SYA_SHIFT_W      5

// Drain steps after the last beat, twice the dimension minus two
`define SYA_FLUSH_STEPS  6

// Configuration word, fields packed from the top down, low byte reserved
`define SYA_CFG_W        77
`define SYA_CFG_OFM_LSB  61
`define SYA_CFG_ACT_LSB  45
`define SYA_CFG_WGT_LSB  29
`define SYA_CFG_CHN_LSB  21
`define SYA_CFG_SHIFT_LSB 16
`define SYA_CFG_ZP_LSB   8

`endif

/* common/sya_pkg.sv */
`default_nettype none

`include "sya_defs.svh"

package sya_pkg;

    // Operands and accumulators
    typedef logic signed [`SYA_DATA_W-1:0] data_t;
    typedef logic signed [`SYA_PSUM_W-1:0] psum_t;

    // One byte per lane, lane i at bits 8i+7:8i
    typedef logic [`SYA_DIM*`SYA_DATA_W-1:0] vec_t;

    // Entry r*DIM+c is row r, column c
    typedef logic [`SYA_DIM*`SYA_DIM*`SYA_PSUM_W-1:0] psum_grid_t;

    typedef logic [`SYA_ADDR_W-1:0]  glb_addr_t;
    typedef logic [`SYA_CHN_W-1:0]   chn_t;
    typedef logic [`SYA_SHIFT_W-1:0] shift_t;
    typedef logic [`SYA_CFG_W-1:0]   cfg_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMP,
        ST_FLUSH,
        ST_WRITE
    } sya_state_t;

endpackage

`default_nettype wire

/* pe_array/sya_pe.sv */
`timescale 1ns/1ns
`default_nettype none

module sya_pe
    import sya_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         en,
    input  wire         clear,
    input  wire data_t  act_in,
    input  wire data_t  wgt_in,
    output data_t       act_out,
    output data_t       wgt_out,
    output psum_t       psum
);

    psum_t product;

    // Signed product, sign extended to the accumulator width
    assign product = act_in * wgt_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_out <= '0;
            wgt_out <= '0;
            psum    <= '0;
        end else if (clear) begin
            act_out <= '0;
            wgt_out <= '0;
            psum    <= '0;
        end else if (en) begin
            act_out <= act_in;
            wgt_out <= wgt_in;
            psum    <= psum + product;
        end
    end

endmodule

`default_nettype wire

/* pe_array/sya_pe_array.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sya_defs.svh"

module sya_pe_array
    import sya_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         en,
    input  wire         clear,
    input  wire vec_t   act_west,
    input  wire vec_t   wgt_north,
    output psum_grid_t  psums
);

    // Horizontal links per row, vertical links per column, edge included
    data_t act_link [`SYA_DIM][`SYA_DIM+1];
    data_t wgt_link [`SYA_DIM+1][`SYA_DIM];

    for (genvar r = 0; r < `SYA_DIM; r++) begin : g_row
        assign act_link[r][0] = act_west[r*`SYA_DATA_W +: `SYA_DATA_W];
    end

    for (genvar c = 0; c < `SYA_DIM; c++) begin : g_col
        assign wgt_link[0][c] = wgt_north[c*`SYA_DATA_W +: `SYA_DATA_W];
    end

    // ========================================
    // Cell grid
    // ========================================
    for (genvar r = 0; r < `SYA_DIM; r++) begin : g_pe_row
        for (genvar c = 0; c < `SYA_DIM; c++) begin : g_pe_col
            sya_pe u_pe (
                .clk     (clk),
                .rst_n   (rst_n),
                .en      (en),
                .clear   (clear),
                .act_in  (act_link[r][c]),
                .wgt_in  (wgt_link[r][c]),
                .act_out (act_link[r][c+1]),
                .wgt_out (wgt_link[r+1][c]),
                .psum    (psums[(r*`SYA_DIM+c)*`SYA_PSUM_W +: `SYA_PSUM_W])
            );
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Verilator build and run of the systolic array testbench
cd "$(dirname "$0")" || exit 1
set -o pipefail
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal --top-module tb_sya_top -Mdir obj_dir \
    -o tb_sya_top -f sya_top.f > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }
./obj_dir/tb_sya_top 2>&1 | tee sim.log || { echo "Simulation did not complete"; exit 1; }
grep -q "Verification failed" sim.log && { echo "Run reported a failure"; exit 1; } \
    || echo "Run reported no failure"

/* sya_top.f */
+incdir+common
common/sya_pkg.sv
verilog/sya_counter.sv
pe_array/sya_pe.sv
pe_array/sya_pe_array.sv
verilog/sya_skew.sv
verilog/sya_ctrl.sv
verilog/sya_ofm_out.sv
verilog/sya_top.sv
bench/tb_sya_top.sv

/* verilog/sya_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module sya_counter #(
    parameter int WIDTH = 8
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              clear,
    input  wire              inc,
    input  wire [WIDTH-1:0]  max_count,
    output logic [WIDTH-1:0] count,
    output logic             at_max
);

    // Clear wins over increment
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (inc) begin
            count <= count + 1'b1;
        end
    end

    assign at_max = (count == max_count);

endmodule

`default_nettype wire

/* verilog/sya_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sya_defs.svh"

module sya_ctrl
    import sya_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire             cfg_vld,
    output logic            cfg_rdy,
    input  wire cfg_t       cfg_info,
    output logic            rd_addr_vld,
    input  wire             rd_addr_rdy,
    output glb_addr_t       act_rd_addr,
    output glb_addr_t       wgt_rd_addr,
    input  wire             rd_dat_vld,
    output logic            array_en,
    output logic            feed_zero,
    output logic            array_clear,
    output logic            write_en,
    output shift_t          shift,
    output data_t           zp,
    output glb_addr_t       ofm_base,
    input  wire             rows_done
);

    localparam int FLUSH_W = $clog2(`SYA_FLUSH_STEPS);

    sya_state_t state;
    sya_state_t state_nxt;
    glb_addr_t  act_base;
    glb_addr_t  wgt_base;
    chn_t       chn;
    chn_t       addr_cnt;
    logic       addr_done;
    logic       addr_fire;
    logic       beat_fire;
    logic       beat_at_last;
    logic       last_beat;
    logic       flush_done;

    // ========================================
    // Configuration capture
    // ========================================
    assign cfg_rdy     = (state == ST_IDLE);
    assign array_clear = cfg_vld & cfg_rdy;

    always_ff @(posedge clk) begin
        if (array_clear) begin
            ofm_base <= cfg_info[`SYA_CFG_OFM_LSB +: `SYA_ADDR_W];
            act_base <= cfg_info[`SYA_CFG_ACT_LSB +: `SYA_ADDR_W];
            wgt_base <= cfg_info[`SYA_CFG_WGT_LSB +: `SYA_ADDR_W];
            chn      <= cfg_info[`SYA_CFG_CHN_LSB +: `SYA_CHN_W];
            shift    <= cfg_info[`SYA_CFG_SHIFT_LSB +: `SYA_SHIFT_W];
            zp       <= cfg_info[`SYA_CFG_ZP_LSB +: `SYA_DATA_W];
        end
    end

    // ========================================
    // Read address issue
    // ========================================
    assign rd_addr_vld = (state == ST_COMP) & ~addr_done;
    assign addr_fire   = rd_addr_vld & rd_addr_rdy;
    assign act_rd_addr = act_base + glb_addr_t'(addr_cnt);
    assign wgt_rd_addr = wgt_base + glb_addr_t'(addr_cnt);

    sya_counter #(.WIDTH(`SYA_CHN_W)) u_addr_cnt (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (array_clear),
        .inc       (addr_fire),
        .max_count (chn),
        .count     (addr_cnt),
        .at_max    (addr_done)
    );

    // Returning beats, in request order
    assign beat_fire = rd_dat_vld & (state == ST_COMP);
    assign last_beat = beat_fire & beat_at_last;

    sya_counter #(.WIDTH(`SYA_CHN_W)) u_beat_cnt (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (array_clear),
        .inc       (beat_fire),
        .max_count (chn_t'(chn - 1'b1)),
        .count     (),
        .at_max    (beat_at_last)
    );

    // Drain steps, restarted by the last beat
    sya_counter #(.WIDTH(FLUSH_W)) u_flush_cnt (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (last_beat),
        .inc       (state == ST_FLUSH),
        .max_count (FLUSH_W'(`SYA_FLUSH_STEPS - 1)),
        .count     (),
        .at_max    (flush_done)
    );

    // ========================================
    // FSM
    // ========================================
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:  if (array_clear) state_nxt = ST_COMP;
            ST_COMP:  if (last_beat) state_nxt = ST_FLUSH;
            ST_FLUSH: if (flush_done) state_nxt = ST_WRITE;
            ST_WRITE: if (rows_done) state_nxt = ST_IDLE;
            default:  state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Array steps on each beat, then freely while draining
    assign array_en  = beat_fire | (state == ST_FLUSH);
    assign feed_zero = (state == ST_FLUSH);
    assign write_en  = (state == ST_WRITE);

endmodule

`default_nettype wire

/* verilog/sya_ofm_out.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sya_defs.svh"

module sya_ofm_out
    import sya_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire              write_en,
    input  wire psum_grid_t  psums,
    input  wire shift_t      shift,
    input  wire data_t       zp,
    input  wire glb_addr_t   ofm_base,
    output logic             ofm_wr_vld,
    input  wire              ofm_wr_rdy,
    output glb_addr_t        ofm_wr_addr,
    output vec_t             ofm_wr_dat,
    output logic             rows_done
);

    localparam int ROW_W = $clog2(`SYA_DIM);

    logic [ROW_W-1:0] row_idx;
    logic             last_row;
    logic             row_fire;

    // Negative sums give zero, others are scaled down and offset by zp
    function automatic logic [`SYA_DATA_W-1:0] requant(psum_t value, shift_t amount,
                                                      data_t offset);
        psum_t scaled;
        if (value[`SYA_PSUM_W-1]) begin
            return '0;
        end
        scaled = value >> amount;
        return scaled[`SYA_DATA_W-1:0] + offset;
    endfunction

    // ========================================
    // Row select and requantize
    // ========================================
    always_comb begin
        for (int c = 0; c < `SYA_DIM; c++) begin
            ofm_wr_dat[c*`SYA_DATA_W +: `SYA_DATA_W] =
                requant(psums[(int'(row_idx)*`SYA_DIM + c)*`SYA_PSUM_W +: `SYA_PSUM_W],
                        shift, zp);
        end
    end

    // Write beats, one row each
    assign ofm_wr_vld  = write_en;
    assign ofm_wr_addr = ofm_base + glb_addr_t'(row_idx);
    assign row_fire    = ofm_wr_vld & ofm_wr_rdy;
    assign rows_done   = row_fire & last_row;

    // Held at row 0 outside the write phase
    sya_counter #(.WIDTH(ROW_W)) u_row_cnt (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (~write_en),
        .inc       (row_fire),
        .max_count (ROW_W'(`SYA_DIM - 1)),
        .count     (row_idx),
        .at_max    (last_row)
    );

endmodule

`default_nettype wire

/* verilog/sya_skew.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sya_defs.svh"

module sya_skew
    import sya_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        en,
    input  wire        clear,
    input  wire        feed_zero,
    input  wire vec_t  act_in,
    input  wire vec_t  wgt_in,
    output vec_t       act_west,
    output vec_t       wgt_north
);

    vec_t act_src;
    vec_t wgt_src;

    // Zeros pushed in while the staircase drains
    assign act_src = feed_zero ? '0 : act_in;
    assign wgt_src = feed_zero ? '0 : wgt_in;

    // Lane i carries activation row i and weight column i and delays both by i steps
    for (genvar i = 0; i < `SYA_DIM; i++) begin : g_lane
        if (i == 0) begin : g_direct
            assign act_west[0 +: `SYA_DATA_W]  = act_src[0 +: `SYA_DATA_W];
            assign wgt_north[0 +: `SYA_DATA_W] = wgt_src[0 +: `SYA_DATA_W];
        end else begin : g_delay
            data_t act_pipe [i];
            data_t wgt_pipe [i];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int k = 0; k < i; k++) begin
                        act_pipe[k] <= '0;
                        wgt_pipe[k] <= '0;
                    end
                end else if (clear) begin
                    for (int k = 0; k < i; k++) begin
                        act_pipe[k] <= '0;
                        wgt_pipe[k] <= '0;
                    end
                end else if (en) begin
                    act_pipe[0] <= act_src[i*`SYA_DATA_W +: `SYA_DATA_W];
                    wgt_pipe[0] <= wgt_src[i*`SYA_DATA_W +: `SYA_DATA_W];
                    for (int k = 1; k < i; k++) begin
                        act_pipe[k] <= act_pipe[k-1];
                        wgt_pipe[k] <= wgt_pipe[k-1];
                    end
                end
            end

            assign act_west[i*`SYA_DATA_W +: `SYA_DATA_W]  = act_pipe[i-1];
            assign wgt_north[i*`SYA_DATA_W +: `SYA_DATA_W] = wgt_pipe[i-1];
        end
    end

endmodule

`default_nettype wire

/* verilog/sya_top.sv */
`timescale 1ns/1ns
`default_nettype none

module sya_top
    import sya_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    // Configuration
    input  wire             cfg_vld,
    output logic            cfg_rdy,
    input  wire cfg_t       cfg_info,
    // Read request
    output logic            rd_addr_vld,
    input  wire             rd_addr_rdy,
    output glb_addr_t       act_rd_addr,
    output glb_addr_t       wgt_rd_addr,
    // Read data
    input  wire             rd_dat_vld,
    input  wire vec_t       act_rd_dat,
    input  wire vec_t       wgt_rd_dat,
    // Output write
    output logic            ofm_wr_vld,
    input  wire             ofm_wr_rdy,
    output glb_addr_t       ofm_wr_addr,
    output vec_t            ofm_wr_dat
);

    logic       array_en;
    logic       feed_zero;
    logic       array_clear;
    logic       write_en;
    logic       rows_done;
    shift_t     shift;
    data_t      zp;
    glb_addr_t  ofm_base;
    vec_t       act_west;
    vec_t       wgt_north;
    psum_grid_t psums;

    sya_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_vld     (cfg_vld),
        .cfg_rdy     (cfg_rdy),
        .cfg_info    (cfg_info),
        .rd_addr_vld (rd_addr_vld),
        .rd_addr_rdy (rd_addr_rdy),
        .act_rd_addr (act_rd_addr),
        .wgt_rd_addr (wgt_rd_addr),
        .rd_dat_vld  (rd_dat_vld),
        .array_en    (array_en),
        .feed_zero   (feed_zero),
        .array_clear (array_clear),
        .write_en    (write_en),
        .shift       (shift),
        .zp          (zp),
        .ofm_base    (ofm_base),
        .rows_done   (rows_done)
    );

    sya_skew u_skew (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (array_en),
        .clear     (array_clear),
        .feed_zero (feed_zero),
        .act_in    (act_rd_dat),
        .wgt_in    (wgt_rd_dat),
        .act_west  (act_west),
        .wgt_north (wgt_north)
    );

    sya_pe_array u_pe_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (array_en),
        .clear     (array_clear),
        .act_west  (act_west),
        .wgt_north (wgt_north),
        .psums     (psums)
    );

    sya_ofm_out u_ofm_out (
        .clk         (clk),
        .rst_n       (rst_n),
        .write_en    (write_en),
        .psums       (psums),
        .shift       (shift),
        .zp          (zp),
        .ofm_base    (ofm_base),
        .ofm_wr_vld  (ofm_wr_vld),
        .ofm_wr_rdy  (ofm_wr_rdy),
        .ofm_wr_addr (ofm_wr_addr),
        .ofm_wr_dat  (ofm_wr_dat),
        .rows_done   (rows_done)
    );

endmodule

`default_nettype wire
